// ==== axi_burst_pkg.sv ====
package axi_burst_pkg;

	// ============================================================
	// fixed AXI field widths
	// ============================================================

	// AxLEN carries beats minus one
	localparam int LEN_WIDTH   = 8;

	// AxBURST code width
	localparam int BURST_WIDTH = 2;

	// xRESP code width
	localparam int RESP_WIDTH  = 2;

	// ============================================================
	// burst and response codes
	// ============================================================

	// AxBURST encodings as the bus defines them
	typedef enum logic [BURST_WIDTH-1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10,
		// reserved code, handled the same as INCR by this slave
		RSVD  = 2'b11
	} burst_e;

	// BRESP / RRESP encodings
	// only OKAY is ever returned here
	typedef enum logic [RESP_WIDTH-1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

endpackage

// ==== mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if #(
	parameter int DATA_WIDTH = 32,
	parameter int MEM_WORDS  = 16
);

	// word index into the RAM
	localparam int IDX_WIDTH = $clog2(MEM_WORDS);

	logic                    en;
	logic [IDX_WIDTH-1:0]    addr;
	logic [DATA_WIDTH-1:0]   wdata;
	// one strobe bit per byte lane
	logic [DATA_WIDTH/8-1:0] wstrb;
	// registered read data, one cycle after en
	logic [DATA_WIDTH-1:0]   rdata;

	// controller side drives the request
	modport ctrl (output en, output addr, output wdata, output wstrb, input rdata);

	// memory side answers with rdata
	modport mem (input en, input addr, input wdata, input wstrb, output rdata);

endinterface

// ==== burst_addr_gen.sv ====
`timescale 1ns/1ps

module burst_addr_gen #(
	parameter int ADDR_WIDTH = 6,
	parameter int DATA_WIDTH = 32
) (
	input  logic [ADDR_WIDTH-1:0]                addr,
	input  logic [axi_burst_pkg::LEN_WIDTH-1:0]  len,
	input  axi_burst_pkg::burst_e                burst,
	output logic [ADDR_WIDTH-1:0]                next_addr
);

	import axi_burst_pkg::*;

	// byte offset bits inside one data word
	localparam int WORD_LSB = $clog2(DATA_WIDTH/8);
	// width of the word part of the address
	localparam int WW = ADDR_WIDTH - WORD_LSB;

	logic [WW-1:0] word;
	logic [WW-1:0] word_inc;
	logic [WW-1:0] wrap_mask;
	logic [WW-1:0] wrap_word;

	assign word     = addr[ADDR_WIDTH-1:WORD_LSB];
	assign word_inc = word + 1'b1;

	// container is len+1 words, so len itself is the low-bit mask
	assign wrap_mask = WW'(len);
	// upper bits pin the container, lower bits roll over inside it
	assign wrap_word = (word & ~wrap_mask) | (word_inc & wrap_mask);

	always_comb
	begin
		case (burst)
			FIXED:   next_addr = addr;
			WRAP:    next_addr = {wrap_word, {WORD_LSB{1'b0}}};
			// INCR and the reserved code step one word, offset cleared
			default: next_addr = {word_inc, {WORD_LSB{1'b0}}};
		endcase
	end

	// the container rule only holds for power-of-two beat counts
	always_comb
	begin
		if (burst == WRAP)
			assert #0 (len == 1 || len == 3 || len == 7 || len == 15)
				else $error("wrap burst with unsupported len %0d", len);
	end

endmodule

// ==== axi_write_ctrl.sv ====
`timescale 1ns/1ps

module axi_write_ctrl #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 6,
	parameter int MEM_WORDS  = 16
) (
	input  logic                               S_AXI_ACLK,
	input  logic                               S_AXI_ARESETN,
	input  logic [ADDR_WIDTH-1:0]              awaddr,
	input  logic [axi_burst_pkg::LEN_WIDTH-1:0] awlen,
	input  axi_burst_pkg::burst_e              awburst,
	input  logic                               awvalid,
	output logic                               awready,
	input  logic [DATA_WIDTH-1:0]              wdata,
	input  logic [DATA_WIDTH/8-1:0]            wstrb,
	input  logic                               wlast,
	input  logic                               wvalid,
	output logic                               wready,
	output axi_burst_pkg::resp_e               bresp,
	output logic                               bvalid,
	input  logic                               bready,
	input  logic                               rd_busy,
	output logic                               wr_busy,
	mem_port_if.ctrl                           mem
);

	import axi_burst_pkg::*;

	localparam int WORD_LSB  = $clog2(DATA_WIDTH/8);
	localparam int IDX_WIDTH = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wstate_e;

	wstate_e               state;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [ADDR_WIDTH-1:0] next_addr;
	logic [LEN_WIDTH-1:0]  len_q;
	burst_e                burst_q;
	logic [LEN_WIDTH-1:0]  beat_cnt;
	logic                  aw_hs;
	logic                  w_hs;

	assign aw_hs = awvalid && awready;
	assign w_hs  = wvalid && wready;

	// handshake outputs come straight from the state register
	assign wready  = (state == W_DATA);
	assign bvalid  = (state == W_RESP);
	assign bresp   = OKAY;
	// a raised awready already commits the slave to this write
	assign wr_busy = (state != W_IDLE) || awready;

	// ============================================================
	// RAM write port
	// ============================================================
	// each accepted beat lands at the edge that accepts it
	assign mem.en    = w_hs;
	assign mem.addr  = addr_q[WORD_LSB +: IDX_WIDTH];
	assign mem.wdata = wdata;
	assign mem.wstrb = wstrb;

	burst_addr_gen #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) addr_gen_i (
		.addr     (addr_q),
		.len      (len_q),
		.burst    (burst_q),
		.next_addr(next_addr)
	);

	// ============================================================
	// FSM
	// ============================================================
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state    <= W_IDLE;
			awready  <= 1'b0;
			beat_cnt <= '0;
		end
		else
		begin
			case (state)
				W_IDLE:
				begin
					if (aw_hs)
					begin
						awready  <= 1'b0;
						beat_cnt <= '0;
						state    <= W_DATA;
					end
					else
						// hold off while a read burst owns the slave
						awready <= awvalid && !rd_busy;
				end
				W_DATA:
				begin
					if (w_hs)
					begin
						beat_cnt <= beat_cnt + 1'b1;
						if (wlast)
							state <= W_RESP;
					end
				end
				W_RESP:
				begin
					// free only after the B handshake
					if (bready)
						state <= W_IDLE;
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	// burst payload latched at AW and stepped per beat
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_hs)
		begin
			addr_q  <= awaddr;
			len_q   <= awlen;
			burst_q <= awburst;
		end
		else if (w_hs)
			addr_q <= next_addr;
	end

	// master must mark exactly beat awlen+1 as last
	a_wlast_beat: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		w_hs |-> (wlast == (beat_cnt == len_q)))
		else $error("wlast does not match beat count %0d of len %0d", beat_cnt, len_q);

endmodule

// ==== axi_read_ctrl.sv ====
`timescale 1ns/1ps

module axi_read_ctrl #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 6,
	parameter int MEM_WORDS  = 16
) (
	input  logic                               S_AXI_ACLK,
	input  logic                               S_AXI_ARESETN,
	input  logic [ADDR_WIDTH-1:0]              araddr,
	input  logic [axi_burst_pkg::LEN_WIDTH-1:0] arlen,
	input  axi_burst_pkg::burst_e              arburst,
	input  logic                               arvalid,
	output logic                               arready,
	input  logic                               awvalid,
	output logic [DATA_WIDTH-1:0]              rdata,
	output axi_burst_pkg::resp_e               rresp,
	output logic                               rlast,
	output logic                               rvalid,
	input  logic                               rready,
	input  logic                               wr_busy,
	output logic                               rd_busy,
	mem_port_if.ctrl                           mem
);

	import axi_burst_pkg::*;

	localparam int WORD_LSB  = $clog2(DATA_WIDTH/8);
	localparam int IDX_WIDTH = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {R_IDLE, R_FETCH, R_DATA} rstate_e;

	rstate_e               state;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [ADDR_WIDTH-1:0] next_addr;
	logic [LEN_WIDTH-1:0]  len_q;
	burst_e                burst_q;
	logic [LEN_WIDTH-1:0]  beat_cnt;
	logic                  ar_hs;
	logic                  r_hs;

	assign ar_hs = arvalid && arready;
	assign r_hs  = rvalid && rready;

	// R_FETCH is the one-cycle gap while the RAM reads
	assign rvalid  = (state == R_DATA);
	assign rlast   = rvalid && (beat_cnt == len_q);
	assign rresp   = OKAY;
	// RAM output register holds between fetches
	assign rdata   = mem.rdata;
	assign rd_busy = (state != R_IDLE) || arready;

	// ============================================================
	// RAM read port
	// ============================================================
	assign mem.en    = (state == R_FETCH);
	assign mem.addr  = addr_q[WORD_LSB +: IDX_WIDTH];
	// read side never writes
	assign mem.wdata = '0;
	assign mem.wstrb = '0;

	burst_addr_gen #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) addr_gen_i (
		.addr     (addr_q),
		.len      (len_q),
		.burst    (burst_q),
		.next_addr(next_addr)
	);

	// ============================================================
	// FSM
	// ============================================================
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state    <= R_IDLE;
			arready  <= 1'b0;
			beat_cnt <= '0;
		end
		else
		begin
			case (state)
				R_IDLE:
				begin
					if (ar_hs)
					begin
						arready  <= 1'b0;
						beat_cnt <= '0;
						state    <= R_FETCH;
					end
					else
						// a pending write address always goes first
						arready <= arvalid && !wr_busy && !awvalid;
				end
				R_FETCH:
					state <= R_DATA;
				R_DATA:
				begin
					if (r_hs)
					begin
						if (beat_cnt == len_q)
							state <= R_IDLE;
						else
						begin
							beat_cnt <= beat_cnt + 1'b1;
							state    <= R_FETCH;
						end
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	// address steps right after each fetch, ready for the next one
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_hs)
		begin
			addr_q  <= araddr;
			len_q   <= arlen;
			burst_q <= arburst;
		end
		else if (state == R_FETCH)
			addr_q <= next_addr;
	end

	// data from the RAM register must not move under a stalled beat
	a_rdata_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rvalid && !rready |=> $stable(rdata))
		else $error("rdata changed while rvalid high and rready low");

endmodule

// ==== byte_lane_ram.sv ====
`timescale 1ns/1ps

module byte_lane_ram #(
	parameter int DATA_WIDTH = 32,
	parameter int MEM_WORDS  = 16
) (
	input  logic    S_AXI_ACLK,
	mem_port_if.mem wr,
	mem_port_if.mem rd
);

	localparam int LANES = DATA_WIDTH / 8;

	// lanes drive disjoint slices of the read word
	wire [DATA_WIDTH-1:0] rd_word;

	genvar lane;

	// ============================================================
	// one byte-wide array per lane
	// ============================================================
	generate
		for (lane = 0; lane < LANES; lane = lane + 1)
		begin : g_lane
			logic [7:0] lane_mem [MEM_WORDS];
			logic [7:0] rd_byte;

			// lane written only when its strobe bit is set
			always_ff @(posedge S_AXI_ACLK)
			begin
				if (wr.en && wr.wstrb[lane])
					lane_mem[wr.addr] <= wr.wdata[lane*8 +: 8];
			end

			// registered read, held while en is low
			always_ff @(posedge S_AXI_ACLK)
			begin
				if (rd.en)
					rd_byte <= lane_mem[rd.addr];
			end

			assign rd_word[lane*8 +: 8] = rd_byte;
		end
	endgenerate

	assign rd.rdata = rd_word;
	// write port has no read-back path
	assign wr.rdata = '0;

endmodule

// ==== axi_burst_ram.sv ====
`timescale 1ns/1ps

module axi_burst_ram #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 6,
	parameter int MEM_WORDS  = 16
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,

	// ============================================================
	// write address channel
	// ============================================================
	input  logic [ADDR_WIDTH-1:0]                awaddr,
	input  logic [axi_burst_pkg::LEN_WIDTH-1:0]   awlen,
	input  logic [axi_burst_pkg::BURST_WIDTH-1:0] awburst,
	input  logic                                 awvalid,
	output logic                                 awready,

	// write data channel
	input  logic [DATA_WIDTH-1:0]                wdata,
	input  logic [DATA_WIDTH/8-1:0]              wstrb,
	input  logic                                 wlast,
	input  logic                                 wvalid,
	output logic                                 wready,

	// write response channel
	output logic [axi_burst_pkg::RESP_WIDTH-1:0]  bresp,
	output logic                                 bvalid,
	input  logic                                 bready,

	// ============================================================
	// read address channel
	// ============================================================
	input  logic [ADDR_WIDTH-1:0]                araddr,
	input  logic [axi_burst_pkg::LEN_WIDTH-1:0]   arlen,
	input  logic [axi_burst_pkg::BURST_WIDTH-1:0] arburst,
	input  logic                                 arvalid,
	output logic                                 arready,

	// read data channel
	output logic [DATA_WIDTH-1:0]                rdata,
	output logic [axi_burst_pkg::RESP_WIDTH-1:0]  rresp,
	output logic                                 rlast,
	output logic                                 rvalid,
	input  logic                                 rready
);

	import axi_burst_pkg::*;

	// each side tells the other when it owns the slave
	logic wr_busy;
	logic rd_busy;

	// separate RAM ports for the two controllers
	mem_port_if #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) wr_port ();
	mem_port_if #(.DATA_WIDTH(DATA_WIDTH), .MEM_WORDS(MEM_WORDS)) rd_port ();

	axi_write_ctrl #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH),
		.MEM_WORDS (MEM_WORDS)
	) wr_ctrl_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.awaddr       (awaddr),
		.awlen        (awlen),
		.awburst      (burst_e'(awburst)),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.wlast        (wlast),
		.wvalid       (wvalid),
		.wready       (wready),
		.bresp        (bresp),
		.bvalid       (bvalid),
		.bready       (bready),
		.rd_busy      (rd_busy),
		.wr_busy      (wr_busy),
		.mem          (wr_port)
	);

	axi_read_ctrl #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH),
		.MEM_WORDS (MEM_WORDS)
	) rd_ctrl_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.araddr       (araddr),
		.arlen        (arlen),
		.arburst      (burst_e'(arburst)),
		.arvalid      (arvalid),
		.arready      (arready),
		.awvalid      (awvalid),
		.rdata        (rdata),
		.rresp        (rresp),
		.rlast        (rlast),
		.rvalid       (rvalid),
		.rready       (rready),
		.wr_busy      (wr_busy),
		.rd_busy      (rd_busy),
		.mem          (rd_port)
	);

	byte_lane_ram #(
		.DATA_WIDTH(DATA_WIDTH),
		.MEM_WORDS (MEM_WORDS)
	) ram_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.wr        (wr_port),
		.rd        (rd_port)
	);

endmodule

// ==== tb_axi_burst_ram.sv ====
`timescale 1ns/1ps

module tb_axi_burst_ram;

	import axi_burst_pkg::*;

	// roughly 180 beats in all, each allowed about 20 cycles under the heaviest stalls
	localparam int MAX_CYCLES = 4000;

	logic        S_AXI_ACLK;
	logic        S_AXI_ARESETN;
	logic [5:0]  awaddr;
	logic [7:0]  awlen;
	logic [1:0]  awburst;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wlast;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [5:0]  araddr;
	logic [7:0]  arlen;
	logic [1:0]  arburst;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rlast;
	logic        rvalid;
	logic        rready;

	// reference memory, one entry per byte address
	logic [7:0]  ref_mem [64];
	// beat payload staged by a test before each write burst
	logic [31:0] wr_data [16];
	logic [3:0]  wr_strb [16];

	int          errors;
	int          checks;
	int          cycles;
	// completed B handshakes, and the count seen when a read address was taken
	int          b_count;
	int          ar_b_count;
	int unsigned seed_val;

	axi_burst_ram #(
		.DATA_WIDTH(32),
		.ADDR_WIDTH(6),
		.MEM_WORDS (16)
	) axi_burst_ram_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.awaddr       (awaddr),
		.awlen        (awlen),
		.awburst      (awburst),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.wlast        (wlast),
		.wvalid       (wvalid),
		.wready       (wready),
		.bresp        (bresp),
		.bvalid       (bvalid),
		.bready       (bready),
		.araddr       (araddr),
		.arlen        (arlen),
		.arburst      (arburst),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rlast        (rlast),
		.rvalid       (rvalid),
		.rready       (rready)
	);

	initial S_AXI_ACLK = 1'b0;
	always #5 S_AXI_ACLK = ~S_AXI_ACLK;

	// ============================================================
	// reference model
	// ============================================================
	// next beat address from the burst rules
	function automatic int step_addr(input burst_e burst, input int a, input int len);
		int size;
		int base;
		// wrap container is len+1 words, aligned to its own size
		size = (len + 1) * 4;
		base = a - (a % size);
		case (burst)
			FIXED:   step_addr = a;
			WRAP:    step_addr = base + (((a / 4) * 4 - base + 4) % size);
			// INCR and reserved code step one word, offset dropped
			default: step_addr = ((a / 4) * 4 + 4) % 64;
		endcase
	endfunction

	function automatic logic [31:0] ref_word(input int a);
		int w;
		w = (a / 4) * 4;
		ref_word = {ref_mem[w + 3], ref_mem[w + 2], ref_mem[w + 1], ref_mem[w]};
	endfunction

	// strobed write of one beat into the byte array
	task automatic ref_write(input int a, input logic [31:0] data, input logic [3:0] strb);
		for (int lane = 0; lane < 4; lane++)
		begin
			if (strb[lane])
				ref_mem[(a / 4) * 4 + lane] = data[lane * 8 +: 8];
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("mismatch: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		checks++;
		assert (cond === 1'b1)
		else
		begin
			errors++;
			$display("error: %s", msg);
		end
	endtask

	// ============================================================
	// bus tasks, entered and left on a falling edge
	// ============================================================
	// readies are registered, so the value seen at a falling edge
	// decides the handshake at the next rising edge
	task automatic write_burst(input burst_e burst, input logic [5:0] addr, input int len,
		input int gap_pct, input int stall_pct);
		int a;
		a       = addr;
		awaddr  = addr;
		awlen   = 8'(len);
		awburst = burst;
		awvalid = 1'b1;
		while (!awready)
			@(negedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		awvalid = 1'b0;
		for (int i = 0; i <= len; i++)
		begin
			// idle cycles before a beat is offered
			while (($urandom % 100) < gap_pct)
			begin
				wvalid = 1'b0;
				@(negedge S_AXI_ACLK);
			end
			wdata  = wr_data[i];
			wstrb  = wr_strb[i];
			wlast  = (i == len);
			wvalid = 1'b1;
			while (!wready)
				@(negedge S_AXI_ACLK);
			ref_write(a, wr_data[i], wr_strb[i]);
			a = step_addr(burst, a, len);
			@(negedge S_AXI_ACLK);
		end
		wvalid = 1'b0;
		wlast  = 1'b0;
		check_true(!wready, "wready still high after the last write beat");
		check_true(bvalid, "bvalid not raised the cycle after the last write beat");
		bready = 1'b0;
		while (!bready)
		begin
			bready = (($urandom % 100) >= stall_pct);
			check_true(bvalid, "bvalid dropped before the response was taken");
			if (!bready)
				@(negedge S_AXI_ACLK);
		end
		check_value("bresp", bresp, OKAY);
		@(negedge S_AXI_ACLK);
		bready = 1'b0;
		b_count++;
	endtask

	task automatic read_burst(input burst_e burst, input logic [5:0] addr, input int len,
		input int stall_pct);
		int a;
		a       = addr;
		araddr  = addr;
		arlen   = 8'(len);
		arburst = burst;
		arvalid = 1'b1;
		while (!arready)
			@(negedge S_AXI_ACLK);
		ar_b_count = b_count;
		@(negedge S_AXI_ACLK);
		arvalid = 1'b0;
		for (int i = 0; i <= len; i++)
		begin
			while (!rvalid)
				@(negedge S_AXI_ACLK);
			// master back-pressure
			while (($urandom % 100) < stall_pct)
			begin
				rready = 1'b0;
				@(negedge S_AXI_ACLK);
			end
			rready = 1'b1;
			check_value("rdata", rdata, ref_word(a));
			check_value("rlast", rlast, (i == len));
			check_value("rresp", rresp, OKAY);
			a = step_addr(burst, a, len);
			@(negedge S_AXI_ACLK);
			rready = 1'b0;
		end
		check_true(!rvalid, "rvalid high after the final read beat");
	endtask

	task automatic fill_random(input int beats);
		for (int i = 0; i < beats; i++)
		begin
			wr_data[i] = $urandom;
			wr_strb[i] = 4'hf;
		end
	endtask

	// ============================================================
	// directed tests
	// ============================================================
	task automatic test_reset_values();
		check_value("awready", awready, 1'b0);
		check_value("wready", wready, 1'b0);
		check_value("bvalid", bvalid, 1'b0);
		check_value("arready", arready, 1'b0);
		check_value("rvalid", rvalid, 1'b0);
		check_value("rlast", rlast, 1'b0);
	endtask

	task automatic test_incr_full();
		fill_random(16);
		write_burst(INCR, 6'h00, 15, 0, 0);
		read_burst(INCR, 6'h00, 15, 0);
	endtask

	task automatic test_partial_strobe();
		// known pattern first
		for (int i = 0; i < 8; i++)
		begin
			wr_data[i] = 32'h5a5a5a5a ^ (32'h01010101 * i);
			wr_strb[i] = 4'hf;
		end
		write_burst(INCR, 6'h00, 7, 0, 0);
		// mixed strobes, including single lanes and pairs
		for (int i = 0; i < 8; i++)
		begin
			wr_data[i] = $urandom;
			wr_strb[i] = 4'((i * 5 + 3) % 16);
		end
		write_burst(INCR, 6'h00, 7, 0, 0);
		read_burst(INCR, 6'h00, 7, 0);
	endtask

	task automatic test_fixed_rsvd();
		fill_random(4);
		write_burst(FIXED, 6'h24, 3, 0, 0);
		read_burst(FIXED, 6'h24, 3, 0);
		// neighbours must be untouched
		read_burst(INCR, 6'h20, 3, 0);
		// unaligned start, offset dropped after the first beat
		fill_random(4);
		write_burst(RSVD, 6'h31, 3, 0, 0);
		read_burst(INCR, 6'h30, 3, 0);
		read_burst(RSVD, 6'h30, 3, 0);
	endtask

	task automatic test_wrap();
		// word 6 in container 4..7
		fill_random(4);
		write_burst(WRAP, 6'h18, 3, 0, 0);
		read_burst(WRAP, 6'h18, 3, 0);
		read_burst(INCR, 6'h10, 3, 0);
		// word 11 in container 8..15
		fill_random(8);
		write_burst(WRAP, 6'h2c, 7, 0, 0);
		read_burst(WRAP, 6'h2c, 7, 0);
		read_burst(INCR, 6'h20, 7, 0);
	endtask

	task automatic test_stalls();
		fill_random(16);
		write_burst(INCR, 6'h00, 15, 40, 50);
		read_burst(INCR, 6'h00, 15, 50);
		fill_random(8);
		write_burst(WRAP, 6'h24, 7, 40, 50);
		read_burst(WRAP, 6'h24, 7, 50);
		// AW and AR raised together, write goes first
		fill_random(8);
		fork
			write_burst(INCR, 6'h08, 7, 20, 30);
			read_burst(INCR, 6'h08, 7, 30);
		join
		check_true(ar_b_count == b_count, "read accepted before the pending write completed");
	endtask

	task automatic finish_run();
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	// ============================================================
	// run control
	// ============================================================
	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge S_AXI_ACLK);
			cycles++;
		end
		errors++;
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		finish_run();
	end

	initial
	begin
		seed_val      = $urandom(32'h4eaa);
		errors        = 0;
		checks        = 0;
		b_count       = 0;
		ar_b_count    = 0;
		S_AXI_ARESETN = 1'b0;
		awaddr        = '0;
		awlen         = '0;
		awburst       = '0;
		awvalid       = 1'b0;
		wdata         = '0;
		wstrb         = '0;
		wlast         = 1'b0;
		wvalid        = 1'b0;
		bready        = 1'b0;
		araddr        = '0;
		arlen         = '0;
		arburst       = '0;
		arvalid       = 1'b0;
		rready        = 1'b0;
		repeat (5) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		test_reset_values();
		test_incr_full();
		test_partial_strobe();
		test_fixed_rsvd();
		test_wrap();
		test_stalls();
		finish_run();
	end

endmodule

// ==== verilog.f ====
axi_burst_pkg.sv
mem_port_if.sv
burst_addr_gen.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
byte_lane_ram.sv
axi_burst_ram.sv
tb_axi_burst_ram.sv
